//--- bpred.f
logic/bpred_pkg.sv
logic/pipe_reg.sv
logic/pht_bank.sv
logic/history_reg.sv
logic/predict_stage.sv
logic/update_stage.sv
logic/bpred_top.sv
sim/bpred_tb.sv

//--- build.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module bpred_tb -f bpred.f --Mdir obj_dir -o bpred_sim

./obj_dir/bpred_sim

//--- logic/bpred_pkg.sv
package bpred_pkg;

    // table geometry, the global history is as wide as an index
    localparam int INDEX_BITS  = 8;
    localparam int TABLE_DEPTH = 1 << INDEX_BITS;
    localparam int ADDR_BITS   = 32;
    localparam int TAG_BITS    = 8;

    // index bits are taken from the pc starting above the byte offset
    localparam int PC_LSB = 2;

    // 2-bit saturating counter
    // upper bit is taken for direction tables, gshare for the meta table
    typedef logic [1:0] ctr_t;

    localparam ctr_t STRONG_NT = 2'd0;
    localparam ctr_t WEAK_NT   = 2'd1;
    localparam ctr_t WEAK_T    = 2'd2;
    localparam ctr_t STRONG_T  = 2'd3;

    // direction tables start weakly not-taken
    localparam ctr_t CTR_RESET  = WEAK_NT;
    // meta starts weakly bimodal
    localparam ctr_t META_RESET = WEAK_NT;

    typedef struct packed {
        logic [ADDR_BITS-1:0]  pc;
        logic [TAG_BITS-1:0]   tag;
    } bp_req_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [ADDR_BITS-1:0]  pc;
        logic [INDEX_BITS-1:0] gshare_index;
        // bimodal index also selects the meta entry
        logic [INDEX_BITS-1:0] bimodal_index;
        logic [INDEX_BITS-1:0] history;
        ctr_t                  gshare_state;
        ctr_t                  bimodal_state;
        ctr_t                  meta_state;
        logic                  predict_taken;
    } bp_pred_t;

    typedef struct packed {
        bp_pred_t pred;
        logic     actual_taken;
    } bp_resolve_t;

    typedef struct packed {
        logic                  enable;
        logic [INDEX_BITS-1:0] index;
        ctr_t                  state;
    } pht_write_t;

endpackage

//--- logic/bpred_top.sv
`timescale 1ns/1ns

module bpred_top (
    input  logic                   clock,
    input  logic                   reset,

    // fetch request
    input  logic                   req_valid,
    output logic                   req_ready,
    input  bpred_pkg::bp_req_t     req,

    // prediction packet back to fetch
    output logic                   pred_valid,
    input  logic                   pred_ready,
    output bpred_pkg::bp_pred_t    pred,

    // resolved branch from the branch stack
    input  logic                   resolve_valid,
    input  bpred_pkg::bp_resolve_t resolve
);

    // request register to predict stage
    logic                             stage_valid;
    logic                             stage_ready;
    bpred_pkg::bp_req_t               stage_req;
    bpred_pkg::bp_pred_t              stage_pred;

    // table lookups
    logic [bpred_pkg::INDEX_BITS-1:0] gshare_index;
    logic [bpred_pkg::INDEX_BITS-1:0] bimodal_index;
    bpred_pkg::ctr_t                  gshare_state;
    bpred_pkg::ctr_t                  bimodal_state;
    bpred_pkg::ctr_t                  meta_state;

    // training and recovery
    bpred_pkg::pht_write_t            gshare_write;
    bpred_pkg::pht_write_t            bimodal_write;
    bpred_pkg::pht_write_t            meta_write;
    logic                             flush;
    logic [bpred_pkg::INDEX_BITS-1:0] repair_history;
    logic [bpred_pkg::INDEX_BITS-1:0] history;

    logic                             issue;

    // a packet entering the output register commits its speculative history
    assign issue = stage_valid && stage_ready;

    pipe_reg #(
        .payload_t (bpred_pkg::bp_req_t)
    ) req_reg (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (stage_valid),
        .out_ready (stage_ready),
        .out_data  (stage_req)
    );

    predict_stage predict_i (
        .req           (stage_req),
        .history       (history),
        .gshare_index  (gshare_index),
        .bimodal_index (bimodal_index),
        .gshare_state  (gshare_state),
        .bimodal_state (bimodal_state),
        .meta_state    (meta_state),
        .pred          (stage_pred)
    );

    pipe_reg #(
        .payload_t (bpred_pkg::bp_pred_t)
    ) out_reg (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (stage_valid),
        .in_ready  (stage_ready),
        .in_data   (stage_pred),
        .out_valid (pred_valid),
        .out_ready (pred_ready),
        .out_data  (pred)
    );

    pht_bank #(.reset_state(bpred_pkg::CTR_RESET)) gshare_bank (
        .clock (clock), .reset (reset),
        .rd_index (gshare_index), .rd_state (gshare_state), .write (gshare_write)
    );

    pht_bank #(.reset_state(bpred_pkg::CTR_RESET)) bimodal_bank (
        .clock (clock), .reset (reset),
        .rd_index (bimodal_index), .rd_state (bimodal_state), .write (bimodal_write)
    );

    // meta shares the bimodal index
    pht_bank #(.reset_state(bpred_pkg::META_RESET)) meta_bank (
        .clock (clock), .reset (reset),
        .rd_index (bimodal_index), .rd_state (meta_state), .write (meta_write)
    );

    history_reg history_i (
        .clock          (clock),
        .reset          (reset),
        .shift          (issue),
        .shift_taken    (stage_pred.predict_taken),
        .repair         (flush),
        .repair_history (repair_history),
        .history        (history)
    );

    update_stage update_i (
        .clock          (clock),
        .reset          (reset),
        .resolve_valid  (resolve_valid),
        .resolve        (resolve),
        .gshare_write   (gshare_write),
        .bimodal_write  (bimodal_write),
        .meta_write     (meta_write),
        .flush          (flush),
        .repair_history (repair_history)
    );

endmodule

//--- logic/history_reg.sv
`timescale 1ns/1ns

module history_reg (
    input  logic                             clock,
    input  logic                             reset,

    // speculative update when a prediction is issued
    input  logic                             shift,
    input  logic                             shift_taken,

    // restore from a mispredicted branch
    input  logic                             repair,
    input  logic [bpred_pkg::INDEX_BITS-1:0] repair_history,

    output logic [bpred_pkg::INDEX_BITS-1:0] history
);

    logic [bpred_pkg::INDEX_BITS-1:0] history_q;

    assign history = history_q;

    // repair beats a shift in the same cycle
    // the shifted prediction belonged to the wrong path anyway
    always_ff @(posedge clock) begin
        if (reset) begin
            history_q <= '0;
        end else if (repair) begin
            history_q <= repair_history;
        end else if (shift) begin
            // newest outcome enters at bit 0
            history_q <= {history_q[bpred_pkg::INDEX_BITS-2:0], shift_taken};
        end
    end

endmodule

//--- logic/pht_bank.sv
`timescale 1ns/1ns

module pht_bank #(
    parameter bpred_pkg::ctr_t reset_state = bpred_pkg::CTR_RESET
) (
    input  logic                              clock,
    input  logic                              reset,

    // lookup side, read through without a clock
    input  logic [bpred_pkg::INDEX_BITS-1:0]  rd_index,
    output bpred_pkg::ctr_t                   rd_state,

    // training side from the update stage
    input  bpred_pkg::pht_write_t             write
);

    bpred_pkg::ctr_t counters [bpred_pkg::TABLE_DEPTH];

    assign rd_state = counters[rd_index];

    // every entry goes back to its starting state on reset
    // one entry per cycle is trained otherwise
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < bpred_pkg::TABLE_DEPTH; i++) begin
                counters[i] <= reset_state;
            end
        end else if (write.enable) begin
            counters[write.index] <= write.state;
        end
    end

endmodule

//--- logic/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // slot can take a new item when empty or when its item leaves this cycle
    assign in_ready = !valid_q || out_ready;

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // flush drops both the held item and anything arriving at the same edge
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

//--- logic/predict_stage.sv
`timescale 1ns/1ns

module predict_stage (
    // request held in the request register
    input  bpred_pkg::bp_req_t                req,
    input  logic [bpred_pkg::INDEX_BITS-1:0]  history,

    // table read addresses
    output logic [bpred_pkg::INDEX_BITS-1:0]  gshare_index,
    output logic [bpred_pkg::INDEX_BITS-1:0]  bimodal_index,

    // table read data
    input  bpred_pkg::ctr_t                   gshare_state,
    input  bpred_pkg::ctr_t                   bimodal_state,
    input  bpred_pkg::ctr_t                   meta_state,

    output bpred_pkg::bp_pred_t               pred
);

    logic use_gshare;
    logic gshare_taken;
    logic bimodal_taken;

    // bimodal index is the pc alone, above the instruction byte offset
    assign bimodal_index = req.pc[bpred_pkg::PC_LSB +: bpred_pkg::INDEX_BITS];

    // gshare folds the global history into the same pc bits
    assign gshare_index = bimodal_index ^ history;

    // meta upper bit picks gshare
    assign use_gshare    = meta_state[1];
    assign gshare_taken  = gshare_state[1];
    assign bimodal_taken = bimodal_state[1];

    always_comb begin
        pred.tag           = req.tag;
        pred.pc            = req.pc;
        pred.gshare_index  = gshare_index;
        pred.bimodal_index = bimodal_index;
        // snapshot before this prediction shifts the history
        pred.history       = history;
        // all three states ride along so resolve can train without a read
        pred.gshare_state  = gshare_state;
        pred.bimodal_state = bimodal_state;
        pred.meta_state    = meta_state;
        if (use_gshare) begin
            pred.predict_taken = gshare_taken;
        end else begin
            pred.predict_taken = bimodal_taken;
        end
    end

endmodule

//--- logic/update_stage.sv
`timescale 1ns/1ns

module update_stage (
    input  logic                              clock,
    input  logic                              reset,

    // resolved branch from the branch stack, no back-pressure
    input  logic                              resolve_valid,
    input  bpred_pkg::bp_resolve_t            resolve,

    output bpred_pkg::pht_write_t             gshare_write,
    output bpred_pkg::pht_write_t             bimodal_write,
    output bpred_pkg::pht_write_t             meta_write,

    // misprediction recovery, same cycle as the resolve
    output logic                              flush,
    output logic [bpred_pkg::INDEX_BITS-1:0]  repair_history
);

    logic                   pending_valid;
    bpred_pkg::bp_resolve_t pending;
    logic                   gshare_right;
    logic                   bimodal_right;

    // one step toward the outcome, held at either end
    function automatic bpred_pkg::ctr_t ctr_step(bpred_pkg::ctr_t state, logic up);
        bpred_pkg::ctr_t next;
        case (state)
            bpred_pkg::STRONG_NT: next = up ? bpred_pkg::WEAK_NT  : bpred_pkg::STRONG_NT;
            bpred_pkg::WEAK_NT:   next = up ? bpred_pkg::WEAK_T   : bpred_pkg::STRONG_NT;
            bpred_pkg::WEAK_T:    next = up ? bpred_pkg::STRONG_T : bpred_pkg::WEAK_NT;
            default:              next = up ? bpred_pkg::STRONG_T : bpred_pkg::WEAK_T;
        endcase
        return next;
    endfunction

    // wrong direction means everything younger is on a bad path
    assign flush = resolve_valid && (resolve.pred.predict_taken != resolve.actual_taken);

    // history as it would have been had the branch been predicted right
    assign repair_history = {resolve.pred.history[bpred_pkg::INDEX_BITS-2:0],
                             resolve.actual_taken};

    always_ff @(posedge clock) begin
        if (reset) begin
            pending_valid <= 1'b0;
        end else begin
            pending_valid <= resolve_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_valid) begin
            pending <= resolve;
        end
    end

    // which direction tables got this branch right
    assign gshare_right  = pending.pred.gshare_state[1] == pending.actual_taken;
    assign bimodal_right = pending.pred.bimodal_state[1] == pending.actual_taken;

    always_comb begin
        // both direction tables always train
        gshare_write.enable  = pending_valid;
        gshare_write.index   = pending.pred.gshare_index;
        gshare_write.state   = ctr_step(pending.pred.gshare_state, pending.actual_taken);

        bimodal_write.enable = pending_valid;
        bimodal_write.index  = pending.pred.bimodal_index;
        bimodal_write.state  = ctr_step(pending.pred.bimodal_state, pending.actual_taken);

        // chooser only learns when the two tables disagree on correctness
        // upward is toward gshare
        meta_write.enable    = pending_valid && (gshare_right != bimodal_right);
        meta_write.index     = pending.pred.bimodal_index;
        meta_write.state     = ctr_step(pending.pred.meta_state, gshare_right);
    end

endmodule

//--- sim/bpred_tb.sv
`timescale 1ns/1ns

module bpred_tb;

    // cycle budget per test with the watchdog margin on top
    localparam int RESET_CYCLES    = 3;
    localparam int SERIAL_ROUNDS   = 300;
    localparam int STREAM_COUNT    = 200;
    localparam int TEST_CYCLES     = 20 + SERIAL_ROUNDS * 12 + STREAM_COUNT * 10 + 40 + 40;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 200;

    logic                   clock;
    logic                   reset;
    logic                   req_valid;
    logic                   req_ready;
    bpred_pkg::bp_req_t     req;
    logic                   pred_valid;
    logic                   pred_ready;
    bpred_pkg::bp_pred_t    pred;
    logic                   resolve_valid;
    bpred_pkg::bp_resolve_t resolve;

    // reference model of the three tables and the global history
    bpred_pkg::ctr_t                  gshare_model  [bpred_pkg::TABLE_DEPTH];
    bpred_pkg::ctr_t                  bimodal_model [bpred_pkg::TABLE_DEPTH];
    bpred_pkg::ctr_t                  meta_model    [bpred_pkg::TABLE_DEPTH];
    logic [bpred_pkg::INDEX_BITS-1:0] history_model;

    // requests waiting for their packet while streaming
    bpred_pkg::bp_req_t              sent_q [$];
    // most recent packet seen and later resolved as an older branch
    bpred_pkg::bp_pred_t             last_pkt;
    logic [bpred_pkg::ADDR_BITS-1:0] pc_set  [4];
    logic                            pc_bias [4];
    logic                            stream_done;
    int unsigned                     seed_ret;

    bpred_top dut_i (
        .clock         (clock),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .pred_valid    (pred_valid),
        .pred_ready    (pred_ready),
        .pred          (pred),
        .resolve_valid (resolve_valid),
        .resolve       (resolve)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_pred(input string name, input bpred_pkg::bp_pred_t expected,
                              input bpred_pkg::bp_pred_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "prediction packet differs");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %b actual %b", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "handshake flag differs");
        end
    endtask

    // counter moves one step toward the outcome and sticks at either end
    function automatic bpred_pkg::ctr_t saturate_toward(input bpred_pkg::ctr_t state,
                                                        input logic up);
        if (up) begin
            return (state == bpred_pkg::STRONG_T) ? state : state + 2'd1;
        end
        return (state == bpred_pkg::STRONG_NT) ? state : state - 2'd1;
    endfunction

    function automatic bpred_pkg::bp_pred_t predict_from_model(input bpred_pkg::bp_req_t r);
        bpred_pkg::bp_pred_t p;
        p.tag           = r.tag;
        p.pc            = r.pc;
        p.bimodal_index = r.pc[bpred_pkg::PC_LSB +: bpred_pkg::INDEX_BITS];
        p.gshare_index  = p.bimodal_index ^ history_model;
        p.history       = history_model;
        p.gshare_state  = gshare_model[p.gshare_index];
        p.bimodal_state = bimodal_model[p.bimodal_index];
        p.meta_state    = meta_model[p.bimodal_index];
        // meta upper bit selects gshare
        p.predict_taken = p.meta_state[1] ? p.gshare_state[1] : p.bimodal_state[1];
        return p;
    endfunction

    task automatic shift_model(input logic taken);
        history_model = {history_model[bpred_pkg::INDEX_BITS-2:0], taken};
    endtask

    task automatic train_model(input bpred_pkg::bp_resolve_t rs);
        logic g_ok;
        logic b_ok;
        g_ok = rs.pred.gshare_state[1] == rs.actual_taken;
        b_ok = rs.pred.bimodal_state[1] == rs.actual_taken;
        gshare_model[rs.pred.gshare_index] =
            saturate_toward(rs.pred.gshare_state, rs.actual_taken);
        bimodal_model[rs.pred.bimodal_index] =
            saturate_toward(rs.pred.bimodal_state, rs.actual_taken);
        // chooser moves only when exactly one table was right
        if (g_ok != b_ok) begin
            meta_model[rs.pred.bimodal_index] = saturate_toward(rs.pred.meta_state, g_ok);
        end
        if (rs.pred.predict_taken != rs.actual_taken) begin
            history_model = {rs.pred.history[bpred_pkg::INDEX_BITS-2:0], rs.actual_taken};
        end
    endtask

    // called just after a rising edge and returns at the transfer edge
    task automatic drive_request(input bpred_pkg::bp_req_t r);
        req_valid <= 1'b1;
        req       <= r;
        @(negedge clock);
        while (!req_ready) @(negedge clock);
        @(posedge clock);
    endtask

    task automatic take_prediction(output bpred_pkg::bp_pred_t p);
        @(negedge clock);
        while (!(pred_valid && pred_ready)) @(negedge clock);
        p = pred;
        @(posedge clock);
    endtask

    task automatic send_resolve(input bpred_pkg::bp_resolve_t rs);
        resolve_valid <= 1'b1;
        resolve       <= rs;
        @(posedge clock);
        resolve_valid <= 1'b0;
        train_model(rs);
    endtask

    // a ends up held in the output register while b waits in the request register
    task automatic stall_pipeline(input bpred_pkg::bp_req_t a, input bpred_pkg::bp_req_t b,
                                  output bpred_pkg::bp_pred_t a_pkt);
        pred_ready <= 1'b0;
        drive_request(a);
        drive_request(b);
        req_valid <= 1'b0;
        a_pkt = predict_from_model(a);
        shift_model(a_pkt.predict_taken);
        @(negedge clock);
        check_flag("stall_pred_valid", 1'b1, pred_valid);
        check_flag("stall_req_ready", 1'b0, req_ready);
        @(posedge clock);
    endtask

    initial begin : main
        bpred_pkg::bp_req_t     r;
        bpred_pkg::bp_req_t     b;
        bpred_pkg::bp_pred_t    got;
        bpred_pkg::bp_pred_t    expected_pkt;
        bpred_pkg::bp_pred_t    a_pkt;
        bpred_pkg::bp_resolve_t rs;
        int                     sel;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        pred_ready    = 1'b0;
        resolve_valid = 1'b0;
        resolve       = '0;
        stream_done   = 1'b0;
        seed_ret      = $urandom(40);
        for (int i = 0; i < bpred_pkg::TABLE_DEPTH; i++) begin
            gshare_model[i]  = bpred_pkg::CTR_RESET;
            bimodal_model[i] = bpred_pkg::CTR_RESET;
            meta_model[i]    = bpred_pkg::META_RESET;
        end
        history_model = '0;
        // a few branches that each lean one way
        for (int i = 0; i < 4; i++) begin
            pc_set[i]  = $urandom;
            pc_bias[i] = 1'($urandom_range(0, 1));
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        // reset state and first lookup
        @(negedge clock);
        check_flag("reset_req_ready", 1'b1, req_ready);
        check_flag("reset_pred_valid", 1'b0, pred_valid);
        @(posedge clock);
        pred_ready <= 1'b1;
        r.pc  = $urandom;
        r.tag = 8'h01;
        drive_request(r);
        req_valid <= 1'b0;
        take_prediction(got);
        expected_pkt.tag           = r.tag;
        expected_pkt.pc            = r.pc;
        expected_pkt.bimodal_index = r.pc[bpred_pkg::PC_LSB +: bpred_pkg::INDEX_BITS];
        expected_pkt.gshare_index  = expected_pkt.bimodal_index;
        expected_pkt.history       = '0;
        expected_pkt.gshare_state  = bpred_pkg::CTR_RESET;
        expected_pkt.bimodal_state = bpred_pkg::CTR_RESET;
        expected_pkt.meta_state    = bpred_pkg::META_RESET;
        expected_pkt.predict_taken = 1'b0;
        check_pred("reset_state", expected_pkt, got);
        shift_model(1'b0);

        // serial lookups with each one resolved before the next
        for (int round = 0; round < SERIAL_ROUNDS; round++) begin
            sel   = $urandom_range(0, 3);
            r.pc  = pc_set[sel];
            r.tag = 8'(round);
            drive_request(r);
            req_valid <= 1'b0;
            take_prediction(got);
            expected_pkt = predict_from_model(r);
            check_pred("serial_training", expected_pkt, got);
            shift_model(expected_pkt.predict_taken);
            rs.pred         = expected_pkt;
            rs.actual_taken = pc_bias[sel] ^ ($urandom_range(0, 3) == 0);
            send_resolve(rs);
            repeat (2) @(posedge clock);
        end

        // back-to-back requests against a random sink
        fork
            begin : sender
                bpred_pkg::bp_req_t send_r;
                for (int k = 0; k < STREAM_COUNT; k++) begin
                    send_r.pc  = $urandom;
                    send_r.tag = 8'(k);
                    sent_q.push_back(send_r);
                    drive_request(send_r);
                end
                req_valid <= 1'b0;
            end
            begin : receiver
                bpred_pkg::bp_pred_t recv_got;
                bpred_pkg::bp_pred_t recv_exp;
                for (int k = 0; k < STREAM_COUNT; k++) begin
                    take_prediction(recv_got);
                    // packets leave in issue order so the queue head is next
                    recv_exp = predict_from_model(sent_q.pop_front());
                    check_pred("stream_backpressure", recv_exp, recv_got);
                    shift_model(recv_exp.predict_taken);
                    last_pkt = recv_got;
                end
                stream_done = 1'b1;
            end
            begin : sink
                while (!stream_done) begin
                    @(posedge clock);
                    pred_ready <= 1'($urandom_range(0, 1));
                end
                pred_ready <= 1'b1;
            end
        join

        // wrong direction on an older branch empties the pipeline
        r.pc  = $urandom;
        r.tag = 8'he1;
        b.pc  = $urandom;
        b.tag = 8'he2;
        stall_pipeline(r, b, a_pkt);
        rs.pred         = last_pkt;
        rs.actual_taken = !last_pkt.predict_taken;
        send_resolve(rs);
        @(negedge clock);
        check_flag("flush_pred_valid", 1'b0, pred_valid);
        check_flag("flush_req_ready", 1'b1, req_ready);
        @(posedge clock);
        pred_ready <= 1'b1;
        // neither dropped item may surface while the pipeline idles
        repeat (2) begin
            @(negedge clock);
            check_flag("flush_dropped", 1'b0, pred_valid);
            @(posedge clock);
        end
        // same pc again so the trained entries and repaired history show
        r.pc  = rs.pred.pc;
        r.tag = 8'he3;
        drive_request(r);
        req_valid <= 1'b0;
        take_prediction(got);
        expected_pkt = predict_from_model(r);
        check_pred("flush_repair", expected_pkt, got);
        shift_model(expected_pkt.predict_taken);
        last_pkt = got;

        // right direction keeps both in-flight items
        r.pc  = $urandom;
        r.tag = 8'hf1;
        b.pc  = last_pkt.pc;
        b.tag = 8'hf2;
        stall_pipeline(r, b, a_pkt);
        rs.pred         = last_pkt;
        rs.actual_taken = last_pkt.predict_taken;
        send_resolve(rs);
        @(negedge clock);
        check_flag("keep_pred_valid", 1'b1, pred_valid);
        @(posedge clock);
        repeat (2) @(posedge clock);
        pred_ready <= 1'b1;
        take_prediction(got);
        check_pred("keep_first", a_pkt, got);
        take_prediction(got);
        expected_pkt = predict_from_model(b);
        check_pred("keep_second", expected_pkt, got);
        shift_model(expected_pkt.predict_taken);

        $display(">>> PASS");
        $finish;
    end

endmodule
